//--- design/capture_framer.sv
/* capture opens and closes only when the engine latency counter is zero.
   adc_valid_i must be high on the closing cycle or the trailer is lost */
module capture_framer (
  input  logic                  clk_245_76MHz,
  input  logic                  cpu_reset,
  input  logic                  adc_enable_i,
  input  logic                  adc_valid_i,
  input  logic                  chirp_init_i,
  input  chirp_pkg::chirp_src_e chirp_src_i,
  output logic                  wr_en_o,
  output logic                  frame_first_o,
  output logic                  frame_last_o
);

  logic                    en_r;
  logic                    en_rr;
  capture_pkg::delay_cnt_t delay_cnt;
  capture_pkg::delay_cnt_t delay_sel;
  capture_pkg::align_cnt_t word_cnt;
  capture_pkg::align_cnt_t pad_cnt;
  logic                    delay_zero;
  logic                    pad_pend;
  logic                    frame_open;
  logic                    pre_last;
  logic                    first_r;

  // latency of whichever engine is selected
  assign delay_sel = (chirp_src_i == chirp_pkg::SRC_WFRM) ?
                     capture_pkg::DDS_WFRM_DELAY : capture_pkg::DDS_CHIRP_DELAY;

  assign delay_zero = (delay_cnt == '0);
  assign pad_pend   = (pad_cnt != '0);

  // enable seen, capture not yet running
  assign frame_open = delay_zero & en_r & ~en_rr;
  // one cycle before capture would fall
  assign pre_last   = (delay_cnt == 8'd1) & en_rr & ~en_r;

  //////////////////////////////////////////////////////////////////////
  // enable pipeline
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r  <= 1'b0;
      en_rr <= 1'b0;
    end else begin
      en_r <= adc_enable_i;
      // frozen while the engine catches up or padding runs
      if (delay_zero && !pad_pend) begin
        en_rr <= en_r;
      end
    end
  end

  // reload on chirp start or on enable drop
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      delay_cnt <= '0;
    end else if (chirp_init_i || (en_r && !adc_enable_i)) begin
      delay_cnt <= delay_sel;
    end else if (!delay_zero) begin
      delay_cnt <= delay_cnt - 8'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////////////////////////

  // words written so far, modulo the granule
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt <= '0;
    end else if (frame_open) begin
      word_cnt <= '0;
    end else if (wr_en_o) begin
      word_cnt <= word_cnt + 3'd1;
    end
  end

  // extra words so the trailer lands on the last granule slot
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      pad_cnt <= '0;
    end else if (pre_last) begin
      pad_cnt <= capture_pkg::ALIGN_LAST - (word_cnt + 3'd1);
    end else if (pad_pend) begin
      pad_cnt <= pad_cnt - 3'd1;
    end
  end

  // header flag, lines up with first en_rr cycle
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_r <= 1'b0;
    end else begin
      first_r <= frame_open;
    end
  end

  assign wr_en_o       = en_rr & adc_valid_i;
  assign frame_first_o = first_r;
  // capture falls after this write
  assign frame_last_o  = delay_zero & en_rr & ~en_r & ~pad_pend;

  first_not_last_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(frame_first_o && frame_last_o))
    else $error("header and trailer on the same word");

  // the adc must be valid when the frame closes
  last_with_write_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> wr_en_o)
    else $error("trailer without a sample write");

endmodule

//--- design/capture_pkg.sv
/* widths, route codes and engine latencies of the 245.76 MHz capture path.
   delays are fixed per engine and must track the external DDS and waveform player */
package capture_pkg;

  // one i or q component
  localparam int IQ_COMP_W = 16;

  // frame word halves
  localparam int HALF_W = 2 * IQ_COMP_W;

  // i in the upper 16 bits, q in the lower
  typedef logic [2*IQ_COMP_W-1:0] iq_sample_t;
  typedef logic [HALF_W-1:0]      half_word_t;
  // upper half then lower half
  typedef logic [2*HALF_W-1:0]    frame_word_t;
  typedef logic [HALF_W-1:0]      counter_t;

  // source of one routed 32-bit half
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_SAMPLE_CNT = 2'd2,
    ROUTE_GLOBAL_CNT = 2'd3
  } route_sel_e;

  typedef logic [7:0] delay_cnt_t;

  // engine latencies in clock cycles
  localparam delay_cnt_t DDS_CHIRP_DELAY = 8'd3;
  localparam delay_cnt_t DDS_WFRM_DELAY  = 8'd19;

  // frames are padded to a whole number of granules
  localparam int FRAME_ALIGN_WORDS = 8;

  typedef logic [2:0] align_cnt_t;

  // last word position inside a granule
  localparam align_cnt_t ALIGN_LAST = align_cnt_t'(FRAME_ALIGN_WORDS - 1);

endpackage

//--- design/chirp_pkg.sv
/* chirp engine select and host control word layout.
   the waveform player is picked only when both source bits are set */
package chirp_pkg;

  // which external engine runs the chirp
  typedef enum logic {
    SRC_DDS  = 1'b0,
    SRC_WFRM = 1'b1
  } chirp_src_e;

  typedef logic [31:0] control_word_t;

  // two-bit field, route of the lower frame half
  localparam int CTRL_ROUTE_LO_LSB = 0;

  // two-bit field, route of the upper frame half
  localparam int CTRL_ROUTE_HI_LSB = 4;

  // two-bit field, engine source
  localparam int CTRL_SRC_LSB = 8;

endpackage

//--- design/chirp_source_mux.sv
/* the source only changes while chirp_enable_i is low.
   strobes and status are combinational, no added latency */
module chirp_source_mux (
  input  logic                     clk_245_76MHz,
  input  logic                     cpu_reset,
  input  logic                     chirp_init_i,
  input  logic                     chirp_enable_i,
  input  chirp_pkg::control_word_t chirp_control_word_i,
  input  logic                     dds_ready_i,
  input  logic                     dds_done_i,
  input  logic                     dds_active_i,
  input  logic                     wfrm_ready_i,
  input  logic                     wfrm_done_i,
  input  logic                     wfrm_active_i,
  output logic                     dds_init_o,
  output logic                     dds_enable_o,
  output logic                     wfrm_init_o,
  output logic                     wfrm_enable_o,
  output logic                     chirp_ready_o,
  output logic                     chirp_done_o,
  output logic                     chirp_active_o,
  output chirp_pkg::chirp_src_e    chirp_src_o
);

  chirp_pkg::chirp_src_e src_r;
  logic                  use_wfrm;

  // source latch, frozen for the duration of a chirp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      src_r <= chirp_pkg::SRC_DDS;
    end else if (!chirp_enable_i) begin
      src_r <= (&chirp_control_word_i[chirp_pkg::CTRL_SRC_LSB +: 2]) ?
               chirp_pkg::SRC_WFRM : chirp_pkg::SRC_DDS;
    end
  end

  assign use_wfrm = (src_r == chirp_pkg::SRC_WFRM);

  //////////////////////////////////////////////////////////////////////
  // steering to the engines
  //////////////////////////////////////////////////////////////////////
  assign dds_init_o    = chirp_init_i & ~use_wfrm;
  assign dds_enable_o  = chirp_enable_i & ~use_wfrm;
  assign wfrm_init_o   = chirp_init_i & use_wfrm;
  assign wfrm_enable_o = chirp_enable_i & use_wfrm;

  // status of the selected engine only
  assign chirp_ready_o  = use_wfrm ? wfrm_ready_i : dds_ready_i;
  assign chirp_done_o   = use_wfrm ? wfrm_done_i : dds_done_i;
  assign chirp_active_o = use_wfrm ? wfrm_active_i : dds_active_i;

  assign chirp_src_o = src_r;

  // both engines must never see one init
  init_one_engine_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(dds_init_o && wfrm_init_o))
    else $error("chirp init reached both engines");

endmodule

//--- design/fmc150_capture_top.sv
/* capture path top, all ports in the 245.76 MHz domain.
   the sink takes every valid word, there is no ready */
module fmc150_capture_top (
  input  logic                     clk_245_76MHz,
  input  logic                     cpu_reset,
  // host chirp control
  input  logic                     chirp_init_i,
  input  logic                     chirp_enable_i,
  input  chirp_pkg::control_word_t chirp_control_word_i,
  output logic                     chirp_ready_o,
  output logic                     chirp_done_o,
  output logic                     chirp_active_o,
  // external engines
  input  logic                     dds_ready_i,
  input  logic                     dds_done_i,
  input  logic                     dds_active_i,
  input  logic                     wfrm_ready_i,
  input  logic                     wfrm_done_i,
  input  logic                     wfrm_active_i,
  output logic                     dds_init_o,
  output logic                     dds_enable_o,
  output logic                     wfrm_init_o,
  output logic                     wfrm_enable_o,
  // samples in
  input  logic                     adc_enable_i,
  input  logic                     adc_valid_i,
  input  capture_pkg::iq_sample_t  adc_iq_i,
  input  capture_pkg::iq_sample_t  dac_iq_i,
  // frame out
  output capture_pkg::frame_word_t frame_word_o,
  output logic                     frame_valid_o,
  output logic                     frame_first_o,
  output logic                     frame_last_o
);

  chirp_pkg::chirp_src_e chirp_src;
  logic                  wr_en;
  logic                  frame_first;
  logic                  frame_last;

  chirp_source_mux chirp_source_mux_i (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .chirp_init_i         (chirp_init_i),
    .chirp_enable_i       (chirp_enable_i),
    .chirp_control_word_i (chirp_control_word_i),
    .dds_ready_i          (dds_ready_i),
    .dds_done_i           (dds_done_i),
    .dds_active_i         (dds_active_i),
    .wfrm_ready_i         (wfrm_ready_i),
    .wfrm_done_i          (wfrm_done_i),
    .wfrm_active_i        (wfrm_active_i),
    .dds_init_o           (dds_init_o),
    .dds_enable_o         (dds_enable_o),
    .wfrm_init_o          (wfrm_init_o),
    .wfrm_enable_o        (wfrm_enable_o),
    .chirp_ready_o        (chirp_ready_o),
    .chirp_done_o         (chirp_done_o),
    .chirp_active_o       (chirp_active_o),
    .chirp_src_o          (chirp_src)
  );

  // selected engine sets the capture latency
  capture_framer capture_framer_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .adc_valid_i   (adc_valid_i),
    .chirp_init_i  (chirp_init_i),
    .chirp_src_i   (chirp_src),
    .wr_en_o       (wr_en),
    .frame_first_o (frame_first),
    .frame_last_o  (frame_last)
  );

  sample_word_router sample_word_router_i (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .wr_en_i              (wr_en),
    .frame_first_i        (frame_first),
    .frame_last_i         (frame_last),
    .adc_iq_i             (adc_iq_i),
    .dac_iq_i             (dac_iq_i),
    .chirp_control_word_i (chirp_control_word_i),
    .frame_word_o         (frame_word_o),
    .frame_valid_o        (frame_valid_o),
    .frame_first_o        (frame_first_o),
    .frame_last_o         (frame_last_o)
  );

endmodule

//--- design/sample_word_router.sv
/* output is registered, one cycle behind wr_en_i, with no back-pressure.
   header and trailer carry the counters as they stood before the write */
module sample_word_router (
  input  logic                     clk_245_76MHz,
  input  logic                     cpu_reset,
  input  logic                     wr_en_i,
  input  logic                     frame_first_i,
  input  logic                     frame_last_i,
  input  capture_pkg::iq_sample_t  adc_iq_i,
  input  capture_pkg::iq_sample_t  dac_iq_i,
  input  chirp_pkg::control_word_t chirp_control_word_i,
  output capture_pkg::frame_word_t frame_word_o,
  output logic                     frame_valid_o,
  output logic                     frame_first_o,
  output logic                     frame_last_o
);

  capture_pkg::counter_t   glbl_cnt;
  capture_pkg::counter_t   smp_cnt;
  capture_pkg::route_sel_e route_lo_r;
  capture_pkg::route_sel_e route_hi_r;
  capture_pkg::half_word_t half_lo;
  capture_pkg::half_word_t half_hi;

  // pick one of the four half-word sources
  function automatic capture_pkg::half_word_t route_half(
    input capture_pkg::route_sel_e sel,
    input capture_pkg::iq_sample_t adc,
    input capture_pkg::iq_sample_t dac,
    input capture_pkg::counter_t   scnt,
    input capture_pkg::counter_t   gcnt
  );
    case (sel)
      capture_pkg::ROUTE_ADC_IQ:     return adc;
      capture_pkg::ROUTE_DAC_IQ:     return dac;
      capture_pkg::ROUTE_SAMPLE_CNT: return scnt;
      default:                       return gcnt;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // counters and route selects
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt   <= '0;
      smp_cnt    <= '0;
      route_lo_r <= capture_pkg::ROUTE_ADC_IQ;
      route_hi_r <= capture_pkg::ROUTE_ADC_IQ;
    end else begin
      glbl_cnt <= glbl_cnt + 32'd1;
      // header and trailer count too
      if (wr_en_i) begin
        smp_cnt <= smp_cnt + 32'd1;
      end
      route_lo_r <= capture_pkg::route_sel_e'(
                    chirp_control_word_i[chirp_pkg::CTRL_ROUTE_LO_LSB +: 2]);
      route_hi_r <= capture_pkg::route_sel_e'(
                    chirp_control_word_i[chirp_pkg::CTRL_ROUTE_HI_LSB +: 2]);
    end
  end

  assign half_lo = route_half(route_lo_r, adc_iq_i, dac_iq_i, smp_cnt, glbl_cnt);
  assign half_hi = route_half(route_hi_r, adc_iq_i, dac_iq_i, smp_cnt, glbl_cnt);

  // payload word, only loaded on a write
  always_ff @(posedge clk_245_76MHz) begin
    if (wr_en_i) begin
      frame_word_o <= (frame_first_i || frame_last_i) ?
                      {glbl_cnt, smp_cnt} : {half_hi, half_lo};
    end
  end

  // strobes follow the word by one cycle
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      frame_valid_o <= 1'b0;
      frame_first_o <= 1'b0;
      frame_last_o  <= 1'b0;
    end else begin
      frame_valid_o <= wr_en_i;
      frame_first_o <= wr_en_i & frame_first_i;
      frame_last_o  <= wr_en_i & frame_last_i;
    end
  end

endmodule

//--- fmc150_capture.f
design/capture_pkg.sv
design/chirp_pkg.sv
design/chirp_source_mux.sv
design/capture_framer.sv
design/sample_word_router.sv
design/fmc150_capture_top.sv
testbench/tb_fmc150_capture.sv

//--- run_sim.sh
#!/bin/sh
# builds the capture testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module tb_fmc150_capture \
  -Mdir "$BUILD" -f fmc150_capture.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/Vtb_fmc150_capture" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0

//--- testbench/tb_fmc150_capture.sv
/* adc_valid_i stays high after reset, so every frame must close on the 8-word granule.
   the DDS and waveform player are only random status bits, they never answer a chirp */
module tb_fmc150_capture;
  timeunit 1ns;
  timeprecision 1ps;

  // longest sequence below is about 700 cycles
  localparam int MAX_CYCLES = 4000;

  logic                     clk_245_76MHz = 1'b0;
  logic                     cpu_reset;
  logic                     chirp_init_i;
  logic                     chirp_enable_i;
  chirp_pkg::control_word_t chirp_control_word_i;
  logic                     chirp_ready_o;
  logic                     chirp_done_o;
  logic                     chirp_active_o;
  logic                     dds_ready_i;
  logic                     dds_done_i;
  logic                     dds_active_i;
  logic                     wfrm_ready_i;
  logic                     wfrm_done_i;
  logic                     wfrm_active_i;
  logic                     dds_init_o;
  logic                     dds_enable_o;
  logic                     wfrm_init_o;
  logic                     wfrm_enable_o;
  logic                     adc_enable_i;
  logic                     adc_valid_i;
  capture_pkg::iq_sample_t  adc_iq_i;
  capture_pkg::iq_sample_t  dac_iq_i;
  capture_pkg::frame_word_t frame_word_o;
  logic                     frame_valid_o;
  logic                     frame_first_o;
  logic                     frame_last_o;

  integer seed = 32'h8693_de06;

  // check enables, set by the running test
  logic        idle_chk;
  logic        steer_chk;
  logic        want_wfrm;
  int          route_mode;
  logic [31:0] want_delay;

  // reference state built from the output stream
  logic [31:0] glbl_model;
  logic [31:0] words_seen;
  logic [31:0] frame_len;
  logic [31:0] tail_words;
  logic [31:0] hdr_hi;
  logic [31:0] hdr_lo;
  logic [31:0] adc_prev;
  logic [31:0] dac_prev;
  logic        in_frame;

  int fail_cnt         = 0;
  int tests_run        = 0;
  int tests_bad        = 0;
  int test_start_fails = 0;
  int cycle_cnt        = 0;

  // enable lengths picked to land on different granule offsets
  int frame_lens [6] = '{7, 12, 17, 22, 9, 30};

  always #20 clk_245_76MHz = ~clk_245_76MHz;

  fmc150_capture_top dut_i (.*);

  task automatic log_mismatch(input string msg);
    fail_cnt++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (fail_cnt != test_start_fails) begin
      tests_bad++;
      $display("%s: %0d errors", name, fail_cnt - test_start_fails);
    end else begin
      $display("%s: ok", name);
    end
    test_start_fails = fail_cnt;
  endtask

  // hold the enable, then wait for the trailer to leave the DUT
  task automatic run_frame(input int enable_cycles);
    adc_enable_i = 1'b1;
    repeat (enable_cycles) @(negedge clk_245_76MHz);
    adc_enable_i = 1'b0;
    do @(negedge clk_245_76MHz); while (!frame_last_o);
    // let the checks see the trailer
    repeat (3) @(negedge clk_245_76MHz);
  endtask

  // one chirp on the chosen engine, source field flipped mid chirp
  task automatic steer_chirp(input logic wfrm);
    chirp_control_word_i = wfrm ? 32'h0000_0300 : 32'h0000_0000;
    repeat (2) @(negedge clk_245_76MHz);
    want_wfrm = wfrm;
    steer_chk = 1'b1;
    repeat (3) @(negedge clk_245_76MHz);
    chirp_init_i = 1'b1;
    @(negedge clk_245_76MHz);
    chirp_init_i   = 1'b0;
    chirp_enable_i = 1'b1;
    repeat (4) @(negedge clk_245_76MHz);
    chirp_control_word_i = wfrm ? 32'h0000_0000 : 32'h0000_0300;
    repeat (4) @(negedge clk_245_76MHz);
    // source may relatch from the next edge on
    chirp_enable_i = 1'b0;
    steer_chk      = 1'b0;
    repeat (2) @(negedge clk_245_76MHz);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream tracking
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_model <= '0;
      words_seen <= '0;
      frame_len  <= '0;
      tail_words <= '0;
      in_frame   <= 1'b0;
    end else begin
      // free running since reset
      glbl_model <= glbl_model + 32'd1;
      adc_prev   <= adc_iq_i;
      dac_prev   <= dac_iq_i;
      if (frame_valid_o) begin
        words_seen <= words_seen + 32'd1;
      end
      if (frame_valid_o && frame_first_o) begin
        hdr_hi    <= frame_word_o[63:32];
        hdr_lo    <= frame_word_o[31:0];
        frame_len <= 32'd1;
        in_frame  <= 1'b1;
      end else if (frame_valid_o) begin
        frame_len <= frame_len + 32'd1;
      end
      if (frame_last_o) begin
        in_frame <= 1'b0;
      end
      // words seen since adc_enable_i dropped
      if (adc_enable_i) begin
        tail_words <= '0;
      end else if (frame_valid_o) begin
        tail_words <= tail_words + 32'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  idle_quiet_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    idle_chk |-> !(frame_valid_o || frame_first_o || frame_last_o || dds_init_o ||
                   dds_enable_o || wfrm_init_o || wfrm_enable_o))
    else log_mismatch("output active before the first capture");

  steer_strobe_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    steer_chk |-> ((dds_init_o == (chirp_init_i && !want_wfrm)) &&
                   (dds_enable_o == (chirp_enable_i && !want_wfrm)) &&
                   (wfrm_init_o == (chirp_init_i && want_wfrm)) &&
                   (wfrm_enable_o == (chirp_enable_i && want_wfrm))))
    else log_mismatch("chirp strobe on the wrong engine");

  steer_status_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    steer_chk |-> ((chirp_ready_o == (want_wfrm ? wfrm_ready_i : dds_ready_i)) &&
                   (chirp_done_o == (want_wfrm ? wfrm_done_i : dds_done_i)) &&
                   (chirp_active_o == (want_wfrm ? wfrm_active_i : dds_active_i))))
    else log_mismatch("chirp status from the wrong engine");

  // payload halves, one cycle behind the driven samples
  payload_adc_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (route_mode == 1 && frame_valid_o && !frame_first_o && !frame_last_o) |->
      (frame_word_o == {adc_prev, adc_prev}))
    else log_mismatch("payload differs from adc sample");

  payload_dac_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (route_mode == 2 && frame_valid_o && !frame_first_o && !frame_last_o) |->
      (frame_word_o == {dac_prev, adc_prev}))
    else log_mismatch("upper half differs from dac sample");

  // sample count on top, global count below
  payload_cnt_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (route_mode == 3 && frame_valid_o && !frame_first_o && !frame_last_o) |->
      (frame_word_o == {words_seen, glbl_model - 32'd1}))
    else log_mismatch("payload counters wrong");

  frame_open_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_valid_o |-> (frame_first_o == !in_frame))
    else log_mismatch("word outside a frame or header inside one");

  trailer_flag_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> (frame_valid_o && in_frame))
    else log_mismatch("trailer without an open frame");

  // counters as they stood before the header write
  header_counts_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (frame_valid_o && frame_first_o) |-> (frame_word_o == {glbl_model - 32'd1, words_seen}))
    else log_mismatch("header counters wrong");

  trailer_len_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> ((frame_word_o[31:0] - hdr_lo) == frame_len))
    else log_mismatch("trailer sample count does not match frame length");

  trailer_time_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> (frame_word_o[63:32] > hdr_hi))
    else log_mismatch("trailer global count not past header");

  frame_align_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> (((frame_len + 32'd1) & 32'd7) == 32'd0))
    else log_mismatch("frame length not a multiple of 8");

  // two words were already in flight when the drop was sampled, trailer counts
  close_delay_a : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_last_o |-> ((tail_words - 32'd1) >= want_delay))
    else log_mismatch("capture closed before the engine delay");

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // samples and engine status, new on every falling edge
  initial begin
    logic [31:0] rnd;
    adc_iq_i      = '0;
    dac_iq_i      = '0;
    dds_ready_i   = 1'b0;
    dds_done_i    = 1'b0;
    dds_active_i  = 1'b0;
    wfrm_ready_i  = 1'b0;
    wfrm_done_i   = 1'b0;
    wfrm_active_i = 1'b0;
    forever begin
      @(negedge clk_245_76MHz);
      adc_iq_i = $random(seed);
      dac_iq_i = $random(seed);
      rnd      = $random(seed);
      {dds_ready_i, dds_done_i, dds_active_i}    = rnd[2:0];
      {wfrm_ready_i, wfrm_done_i, wfrm_active_i} = rnd[5:3];
    end
  end

  initial begin
    cpu_reset            = 1'b1;
    chirp_init_i         = 1'b0;
    chirp_enable_i       = 1'b0;
    chirp_control_word_i = '0;
    adc_enable_i         = 1'b0;
    adc_valid_i          = 1'b0;
    idle_chk             = 1'b1;
    steer_chk            = 1'b0;
    want_wfrm            = 1'b0;
    route_mode           = 0;
    want_delay           = 32'd3;
    repeat (8) @(negedge clk_245_76MHz);
    cpu_reset   = 1'b0;
    adc_valid_i = 1'b1;

    // quiet outputs after reset
    repeat (20) @(negedge clk_245_76MHz);
    idle_chk = 1'b0;
    close_test("1 idle after reset");

    steer_chirp(1'b1);
    steer_chirp(1'b0);
    close_test("2 chirp steering");

    // both halves adc, then dac on top
    chirp_control_word_i = 32'h0000_0000;
    repeat (3) @(negedge clk_245_76MHz);
    route_mode = 1;
    run_frame(20);
    route_mode = 0;
    chirp_control_word_i = 32'h0000_0010;
    repeat (3) @(negedge clk_245_76MHz);
    route_mode = 2;
    run_frame(13);
    route_mode = 0;
    close_test("3 payload routing");

    // counters in the payload, header and trailer checked on every frame
    chirp_control_word_i = 32'h0000_0023;
    repeat (3) @(negedge clk_245_76MHz);
    route_mode = 3;
    for (int i = 0; i < 3; i++) begin
      run_frame(frame_lens[i]);
    end
    route_mode = 0;
    close_test("4 header and trailer");

    // DDS close delay
    chirp_control_word_i = 32'h0000_0000;
    repeat (3) @(negedge clk_245_76MHz);
    run_frame(frame_lens[3]);
    run_frame(frame_lens[4]);
    // waveform player, second frame waits out a chirp init
    chirp_control_word_i = 32'h0000_0300;
    repeat (2) @(negedge clk_245_76MHz);
    want_delay = 32'd19;
    run_frame(frame_lens[5]);
    chirp_init_i = 1'b1;
    @(negedge clk_245_76MHz);
    chirp_init_i = 1'b0;
    run_frame(frame_lens[1] + 24);
    close_test("5 alignment and close delay");

    $display("tests run %0d, with errors %0d, failed checks %0d",
             tests_run, tests_bad, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit
  always @(posedge clk_245_76MHz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

endmodule
